// File: hdl/pll_cfg_pkg.sv
`default_nettype none

package pll_cfg_pkg;

	localparam int spi_addr_w = 6;	// Register address bits in a frame
	localparam int spi_data_w = 24;	// Register data bits in a frame
	localparam int spi_pulses = 32;	// SCK pulses per frame

	typedef logic [spi_addr_w-1:0] spi_addr_t;
	typedef logic [spi_data_w-1:0] spi_data_t;

	// The first bit on SDI is the read flag, so the encoding follows the wire
	typedef enum logic {
		op_write = 1'b0,
		op_read  = 1'b1
	} spi_op_t;

	// Bits 29 to 24 address, bits 23 to 0 data
	typedef logic [31:0] cfg_word_t;

	localparam int cfg_count = 15;

	// Synthesizer bring-up sequence, written in this order
	localparam cfg_word_t cfg_table [cfg_count] = '{
		32'h02000001,	// Reference divider
		32'h06200B4A,	// Delta-sigma modulator setup
		32'h070008CD,	// Lock detect
		32'h08C1BEFF,	// Analog enables
		32'h09403264,	// Charge pump currents
		32'h0A002046,	// VCO autocal
		32'h0F0000A1,	// GPO and lock detect pin
		32'h05000F88,	// VCO subsystem writes start here
		32'h05007310,
		32'h05002A98,
		32'h05001628,
		32'h050060A0,
		32'h05000000,	// Closes the VCO subsystem access
		32'h03000019,	// Integer divider
		32'h04000000	// Fractional divider, triggers the autocal
	};

	localparam spi_addr_t readback_addr = 6'd2;	// Polled status register

	typedef enum logic [1:0] {
		st_power_wait,
		st_issue,
		st_wait_done,
		st_read_gap
	} seq_state_t;

	typedef enum logic {
		st_idle,
		st_frame
	} eng_state_t;

endpackage

`default_nettype wire

// File: hdl/spi_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_cmd_if import pll_cfg_pkg::*; ();

	logic      start;	// One-cycle request strobe
	spi_op_t   op;	// Valid while start is high
	spi_addr_t addr;
	spi_data_t wdata;
	logic      done;	// One-cycle strobe at the end of the frame
	spi_data_t rdata;	// Holds the result of the last read frame

	modport requester (
		output start,
		output op,
		output addr,
		output wdata,
		input  done,
		input  rdata
	);

	modport server (
		input  start,
		input  op,
		input  addr,
		input  wdata,
		output done,
		output rdata
	);

endinterface

`default_nettype wire

// File: hdl/pll_cfg_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pll_cfg_sequencer import pll_cfg_pkg::*; #(
	parameter int power_up_cycles = 1048576,
	parameter int read_gap_cycles = 256
) (
	input  logic clk,
	input  logic rst,
	spi_cmd_if.requester cmd
);

	localparam int wait_max = (power_up_cycles > read_gap_cycles) ?
		power_up_cycles : read_gap_cycles;
	localparam int cnt_w = $clog2(wait_max + 1);
	localparam int idx_w = $clog2(cfg_count);

	seq_state_t       state;
	logic [cnt_w-1:0] wait_cnt;	// Shared by the power-up wait and the read gap
	logic [idx_w-1:0] idx;	// Table entry on the command lines
	logic             readback;	// Set once the whole table has gone out
	cfg_word_t        entry;

	// Command fields follow the index, so they are ready in the cycle start rises
	assign entry     = cfg_table[idx];
	assign cmd.op    = readback ? op_read : op_write;
	assign cmd.addr  = readback ? readback_addr : entry[spi_addr_w+spi_data_w-1:spi_data_w];
	assign cmd.wdata = entry[spi_data_w-1:0];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= st_power_wait;
			wait_cnt  <= '0;
			idx       <= '0;
			readback  <= 1'b0;
			cmd.start <= 1'b0;
		end else begin
			cmd.start <= 1'b0;
			case (state)
				st_power_wait: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == cnt_w'(power_up_cycles - 1)) begin
						cmd.start <= 1'b1;	// Entry 0 is already on the lines
						state     <= st_issue;
					end
				end
				st_issue: begin
					state <= st_wait_done;
				end
				st_wait_done: begin
					if (cmd.done) begin
						if (idx == idx_w'(cfg_count - 1)) begin
							// Last entry stays selected, the read path ignores it
							readback <= 1'b1;
							wait_cnt <= '0;
							state    <= st_read_gap;
						end else begin
							idx       <= idx + 1'b1;
							cmd.start <= 1'b1;	// Back to back with the previous done
							state     <= st_issue;
						end
					end
				end
				st_read_gap: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == cnt_w'(read_gap_cycles - 1)) begin
						cmd.start <= 1'b1;
						state     <= st_issue;
					end
				end
				default: begin
					state <= st_power_wait;
				end
			endcase
		end
	end

	a_idx_range: assert property (@(posedge clk) disable iff (!rst)
		idx < cfg_count);

	// The engine has no back-pressure, a double strobe would be lost
	a_start_pulse: assert property (@(posedge clk) disable iff (!rst)
		cmd.start |=> !cmd.start);

endmodule

`default_nettype wire

// File: hdl/spi_frame_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_engine import pll_cfg_pkg::*; (
	input  logic clk,
	input  logic rst,
	spi_cmd_if.server cmd,
	output logic sen,
	output logic sck,
	output logic sdi,
	input  logic sdo
);

	// Edge numbers count from the edge that samples start as edge 0
	localparam int last_edge = 2 * spi_pulses + 1;	// Last SCK fall, SEN drops with it
	localparam int done_edge = last_edge + 1;
	localparam int rd_first  = 2 * (spi_addr_w + 2) + 1;	// Fall after pulse 8
	localparam int rd_last   = rd_first + 2 * (spi_data_w - 1);	// Fall after pulse 31
	localparam int edge_w    = $clog2(done_edge + 1);

	eng_state_t            state;
	logic [edge_w-1:0]     edge_cnt;
	logic [spi_pulses-1:0] tx_shift;
	logic [spi_data_w-1:0] rx_shift;
	spi_op_t               op_q;
	logic                  accept;
	logic                  sample_en;

	assign accept = (state == st_idle) && cmd.start;

	// Read data is taken on odd edges, one bit per falling SCK
	assign sample_en = (state == st_frame) && (op_q == op_read) && edge_cnt[0] &&
		(edge_cnt >= edge_w'(rd_first)) && (edge_cnt <= edge_w'(rd_last));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= st_idle;
			edge_cnt <= '0;
			sen      <= 1'b0;
			sck      <= 1'b0;
			sdi      <= 1'b0;
			cmd.done <= 1'b0;
		end else begin
			cmd.done <= 1'b0;
			case (state)
				st_idle: begin
					if (cmd.start) begin
						state    <= st_frame;
						edge_cnt <= edge_w'(1);
					end
				end
				st_frame: begin
					edge_cnt <= edge_cnt + 1'b1;
					if (edge_cnt == edge_w'(done_edge)) begin
						cmd.done <= 1'b1;
						state    <= st_idle;
					end else if (edge_cnt == edge_w'(last_edge)) begin
						sen <= 1'b0;
						sck <= 1'b0;
						sdi <= 1'b0;
					end else if (edge_cnt[0]) begin
						sen <= 1'b1;	// Only changes on edge 1
						sck <= 1'b0;
						sdi <= tx_shift[spi_pulses-1];
					end else begin
						sck <= 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= cmd.op;
			if (cmd.op == op_read) begin
				tx_shift <= {1'b1, cmd.addr, {(spi_data_w + 1){1'b0}}};
			end else begin
				tx_shift <= {1'b0, cmd.addr, cmd.wdata, 1'b0};
			end
		end else if ((state == st_frame) && edge_cnt[0]) begin
			tx_shift <= tx_shift << 1;
		end

		if (sample_en) begin
			rx_shift <= {rx_shift[spi_data_w-2:0], sdo};	// MSB arrives first
		end

		// Result moves over with done and stays until the next read ends
		if ((state == st_frame) && (edge_cnt == edge_w'(done_edge)) && (op_q == op_read)) begin
			cmd.rdata <= rx_shift;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst)
		cmd.start |-> state == st_idle);

endmodule

`default_nettype wire

// File: hdl/pll_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module pll_cfg_top import pll_cfg_pkg::*; #(
	parameter int power_up_cycles = 1048576,
	parameter int read_gap_cycles = 256
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      sdo,
	output logic      sen,
	output logic      sck,
	output logic      sdi,
	output logic      rd_valid,
	output spi_data_t rd_data
);

	spi_cmd_if cmd_if ();

	pll_cfg_sequencer #(
		.power_up_cycles(power_up_cycles),
		.read_gap_cycles(read_gap_cycles)
	) i_sequencer (
		.clk(clk),
		.rst(rst),
		.cmd(cmd_if.requester)
	);

	spi_frame_engine i_frame_engine (
		.clk(clk),
		.rst(rst),
		.cmd(cmd_if.server),
		.sen(sen),
		.sck(sck),
		.sdi(sdi),
		.sdo(sdo)
	);

	// The sequencer holds op for the whole frame, so it tells reads apart at done
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end else begin
			rd_valid <= cmd_if.done && (cmd_if.op == op_read);
			if (cmd_if.done && (cmd_if.op == op_read)) begin
				rd_data <= cmd_if.rdata;
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b0;	// Active from time zero
		repeat (reset_cycles) @(posedge clk);
		#2 rst = 1'b1;	// Released just after an edge, like the other inputs
	end

endmodule

`default_nettype wire

// File: tests/pll_cfg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pll_cfg_checker import pll_cfg_pkg::*; #(
	parameter int power_up_cycles = 64,
	parameter int read_gap_cycles = 20
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      sen,
	input  logic      sck,
	input  logic      sdi,
	input  logic      rd_valid,
	input  spi_data_t rd_data,
	input  spi_data_t model_word,	// Device model's copy of the polled register
	output int        err_count,
	output int        frame_count,
	output int        read_count
);

	typedef struct packed {
		spi_op_t   op;
		spi_addr_t addr;
		spi_data_t data;
	} frame_t;

	logic        sen_q;
	logic        sck_q;
	logic [31:0] bits;	// SDI taken at each rising SCK
	int          pulses;
	int          low_cycles;	// Cycles since SEN last fell
	int          quiet_cycles;
	frame_t      want_frame;
	spi_data_t   want_data;
	spi_data_t   pending [$];	// Readback values still in flight

	// Table writes come first, then reads of the status register forever
	function automatic frame_t expected_frame(input int n);
		frame_t    f;
		cfg_word_t w;
		if (n < cfg_count) begin
			w      = cfg_table[n];
			f.op   = op_write;
			f.addr = w[29:24];
			f.data = w[23:0];
		end else begin
			f.op   = op_read;
			f.addr = readback_addr;
			f.data = '0;	// A read carries zeros after the address
		end
		return f;
	endfunction

	task automatic report_error(input string msg);
		err_count++;
		$display("** Error at time %0t: %s", $realtime, msg);
	endtask

	task automatic check_frame();
		logic [31:0] pins;
		pins = {(want_frame.op == op_read), want_frame.addr, want_frame.data, 1'b0};
		if (pulses != spi_pulses)
			report_error($sformatf("frame %0d has %0d SCK pulses", frame_count, pulses));
		if (bits !== pins)
			report_error($sformatf("frame %0d sent %h on SDI, expected %h",
				frame_count, bits, pins));
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			sen_q        = 1'b0;
			sck_q        = 1'b0;
			bits         = '0;
			pulses       = 0;
			low_cycles   = 0;
			quiet_cycles = 0;
			err_count    = 0;
			frame_count  = 0;
			read_count   = 0;
			pending.delete();
		end else begin
			if (quiet_cycles < power_up_cycles) begin
				quiet_cycles++;
				if (sen || sck || sdi || rd_valid)
					report_error("SPI pins or rd_valid active during the power-up wait");
			end
			if (sen !== sen_q) begin
				if (sck !== 1'b0)
					report_error("SCK is high while SEN changes");
				if (sen) begin
					want_frame = expected_frame(frame_count);
					pulses     = 0;
					bits       = '0;
					if (want_frame.op == op_read) begin
						if (frame_count > cfg_count && low_cycles < read_gap_cycles)
							report_error($sformatf("SEN low for %0d cycles before frame %0d",
								low_cycles, frame_count));
						pending.push_back(model_word);	// What the device shifts out
					end
				end else begin
					check_frame();
					frame_count++;
					low_cycles = 0;
				end
			end
			if (sck && !sck_q) begin
				if (sen) begin
					pulses++;
					bits = {bits[30:0], sdi};
				end else begin
					report_error("SCK pulse while SEN is low");
				end
			end
			if (!sen)
				low_cycles++;
			if (rd_valid) begin
				if (pending.size() == 0) begin
					report_error("rd_valid without a read frame");
				end else begin
					want_data = pending.pop_front();
					read_count++;
					if (rd_data !== want_data)
						report_error($sformatf("rd_data is %h, expected %h", rd_data, want_data));
				end
			end
			sen_q = sen;
			sck_q = sck;
		end
	end

endmodule

`default_nettype wire

// File: tests/pll_cfg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pll_cfg_tb import pll_cfg_pkg::*; ();

	localparam int power_up_cycles = 64;
	localparam int read_gap_cycles = 20;
	localparam int reads_wanted    = 8;
	localparam int clk_period      = 40;
	// Power-up, the table and the reads with their gaps, with a margin of two
	localparam int watchdog_cycles = 2 * (power_up_cycles + cfg_count * 70 +
		reads_wanted * (70 + read_gap_cycles));

	logic        clk;
	logic        rst;
	logic        sdo = 1'b0;
	logic        sen;
	logic        sck;
	logic        sdi;
	logic        rd_valid;
	spi_data_t   rd_data;
	logic        refresh = 1'b0;	// Short pulse that renews the status register
	spi_data_t   regs [2**spi_addr_w];
	spi_data_t   readback_word;
	int          err_count;
	int          frame_count;
	int          read_count;

	tb_clock_gen #(
		.period_ns(clk_period),
		.reset_cycles(4)
	) i_clock_gen (
		.clk(clk),
		.rst(rst)
	);

	pll_cfg_top #(
		.power_up_cycles(power_up_cycles),
		.read_gap_cycles(read_gap_cycles)
	) i_pll_cfg_top (
		.clk(clk),
		.rst(rst),
		.sdo(sdo),
		.sen(sen),
		.sck(sck),
		.sdi(sdi),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	pll_cfg_checker #(
		.power_up_cycles(power_up_cycles),
		.read_gap_cycles(read_gap_cycles)
	) i_checker (
		.clk(clk),
		.rst(rst),
		.sen(sen),
		.sck(sck),
		.sdi(sdi),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.model_word(readback_word),
		.err_count(err_count),
		.frame_count(frame_count),
		.read_count(read_count)
	);

	assign readback_word = regs[readback_addr];

	// Synthesizer register file seen from its SPI pins
	initial begin : device_model
		logic [31:0] shift;
		logic [31:0] rnd;
		int          pulse_no;
		logic        reading;
		spi_data_t   out_word;
		rnd      = $urandom(32'h9d7c);	// Fixed seed for the readback values
		shift    = '0;
		pulse_no = 0;
		reading  = 1'b0;
		out_word = '0;
		for (int a = 0; a < 2**spi_addr_w; a++) begin
			regs[a] = {a[5:0], ~a[5:0], a[5:0], ~a[5:0]};
		end
		forever begin
			@(posedge sck or negedge sen or posedge refresh);
			if (refresh) begin
				rnd = $urandom;
				regs[readback_addr] = rnd[spi_data_w-1:0];
			end else if (!sen) begin
				if (pulse_no == spi_pulses && !shift[31])
					regs[shift[30:25]] = shift[24:1];	// Completed write lands here
				pulse_no = 0;
				reading  = 1'b0;
				sdo <= #2 1'b0;
			end else begin
				shift = {shift[30:0], sdi};
				pulse_no++;
				if (pulse_no == spi_addr_w + 2) begin
					reading  = shift[7];	// Flag and address are complete by pulse 8
					out_word = regs[shift[6:1]];
				end
				if (reading && pulse_no >= spi_addr_w + 2 && pulse_no < spi_pulses) begin
					sdo <= #2 out_word[spi_data_w-1];
					out_word = out_word << 1;
				end else begin
					sdo <= #2 1'b0;
				end
			end
		end
	end

	always @(posedge rd_valid) begin
		#2 refresh = 1'b1;
		#1 refresh = 1'b0;
	end

	initial begin : run_control
		logic frames_ok;
		wait (read_count >= reads_wanted);
		@(posedge clk);
		frames_ok = (frame_count == cfg_count + reads_wanted);
		if (!frames_ok)
			$display("Saw %0d SPI frames where %0d were expected", frame_count,
				cfg_count + reads_wanted);
		$display("Frames: %0d, reads: %0d, errors: %0d", frame_count, read_count, err_count);
		if (frames_ok && err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period);
		$display("Timeout: only %0d of %0d reads finished within %0d cycles", read_count,
			reads_wanted, watchdog_cycles);
		$display("Frames: %0d, reads: %0d, errors: %0d", frame_count, read_count, err_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/pll_cfg_pkg.sv
hdl/spi_cmd_if.sv
hdl/pll_cfg_sequencer.sv
hdl/spi_frame_engine.sv
hdl/pll_cfg_top.sv
tests/tb_clock_gen.sv
tests/pll_cfg_checker.sv
tests/pll_cfg_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module pll_cfg_tb -f vlog.f \
	-o pll_cfg_sim > build.log 2>&1 &&
./obj_dir/pll_cfg_sim > sim.log 2>&1 &&
grep -qF '*** TEST PASSED ***' sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
